// ==== sources.f ====
+incdir+.
ttc_pkg.sv
ttc_interface_lite.sv
ttc_prescaler.sv
ttc_count_engine.sv
ttc_timer_counter_lite.sv
ttc_lite.sv
tb_ttc_lite.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_ttc_lite
FILELIST := sources.f
LOG      := sim.log

.PHONY: sim clean

# Pass is decided by the message in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_ttc_lite.sv ====
`timescale 1ns/10ps
`include "ttc_config.svh"

module tb_ttc_lite;
   import ttc_pkg::*;

   localparam int N_ACCESS = 511;   // Bus transfers issued by the tests
   localparam int N_WAITS  = 22;    // Random idle gaps
   localparam logic [`TTC_ADDR_W-1:0] BASES [9] = '{`TTC_CLK_CTRL_ADDR, `TTC_CNTR_CTRL_ADDR,
      `TTC_CNT_VAL_ADDR, `TTC_INTERVAL_ADDR, `TTC_MATCH_1_ADDR, `TTC_MATCH_2_ADDR,
      `TTC_MATCH_3_ADDR, `TTC_INTR_STAT_ADDR, `TTC_INTR_EN_ADDR};

   logic                       pclk, rst, psel, penable, pwrite;
   logic [`TTC_ADDR_W-1:0]     paddr;
   bus_data_t                  pwdata, prdata;
   logic [`TTC_NUM_TIMERS-1:0] interrupt;

   integer seed;
   int     cycles, limit, wait_sum, wait_idx;
   int     rdata_errs, irq_errs, flag_errs;
   int     wait_len [N_WAITS];

   // Reference model, index 0 is channel 1
   ctrl_word_u m_clk [3], m_cntr [3];
   cnt_t       m_ivl [3], m_m1 [3], m_m2 [3], m_m3 [3], m_cnt [3];
   flags_t     m_stat [3], m_en [3];
   int         m_div [3];                // Cycles since last tick

   ttc_lite dut (
      .pclk      (pclk),
      .rst       (rst),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   always #20 pclk = ~pclk;

   function automatic logic [`TTC_ADDR_W-1:0] reg_addr(input logic [`TTC_ADDR_W-1:0] base,
                                                       input int ch);
      return base + `TTC_ADDR_W'(4 * ch);
   endfunction

   function automatic bus_data_t clk_word(input logic en, input logic [3:0] sel);
      return bus_data_t'({sel, en});
   endfunction

   function automatic bus_data_t cntr_word(input logic dis, input logic ivl, input logic dec,
                                           input logic men, input logic creset);
      return bus_data_t'({creset, men, dec, ivl, dis});
   endfunction

   // Expected read value from the address map
   function automatic bus_data_t model_read(input logic [`TTC_ADDR_W-1:0] addr);
      for (int i = 0; i < 3; i++) begin
         if (addr == reg_addr(`TTC_CLK_CTRL_ADDR, i))  return bus_data_t'(m_clk[i]);
         if (addr == reg_addr(`TTC_CNTR_CTRL_ADDR, i)) return bus_data_t'(m_cntr[i]);
         if (addr == reg_addr(`TTC_CNT_VAL_ADDR, i))   return bus_data_t'(m_cnt[i]);
         if (addr == reg_addr(`TTC_INTERVAL_ADDR, i))  return bus_data_t'(m_ivl[i]);
         if (addr == reg_addr(`TTC_MATCH_1_ADDR, i))   return bus_data_t'(m_m1[i]);
         if (addr == reg_addr(`TTC_MATCH_2_ADDR, i))   return bus_data_t'(m_m2[i]);
         if (addr == reg_addr(`TTC_MATCH_3_ADDR, i))   return bus_data_t'(m_m3[i]);
         if (addr == reg_addr(`TTC_INTR_STAT_ADDR, i)) return bus_data_t'(m_stat[i]);
         if (addr == reg_addr(`TTC_INTR_EN_ADDR, i))   return bus_data_t'(m_en[i]);
      end
      return '0;                             // Unmapped
   endfunction

   function automatic logic [2:0] model_irq();
      logic [2:0] e;
      for (int i = 0; i < 3; i++)
         e[i] = |(m_stat[i] & m_en[i]);
      return e;
   endfunction

   // ------------------------------------------------------------
   // Cycle model, same bus activity as the DUT
   // ------------------------------------------------------------
   always @(posedge pclk) begin : model
      ctrl_word_u w, eff;
      logic       wr, rd, tick, wrap, ctrl_wr, clk_wr, creset;
      cnt_t       nxt;
      flags_t     fs;
      wr = psel & penable & pwrite;
      rd = psel & penable & ~pwrite;
      w  = ctrl_word_u'(pwdata[`TTC_CTRL_W-1:0]);
      for (int i = 0; i < 3; i++) begin
         if (rst) begin
            m_clk[i]  = '0;
            m_cntr[i] = ctrl_word_u'(`TTC_CNTR_CTRL_RST);  // Disabled
            m_ivl[i]  = '0;
            m_m1[i]   = '0;
            m_m2[i]   = '0;
            m_m3[i]   = '0;
            m_cnt[i]  = '0;
            m_stat[i] = '0;
            m_en[i]   = '0;
            m_div[i]  = 0;
         end else begin
            tick    = !m_clk[i].clk.prescale_en || m_div[i] == (2 << m_clk[i].clk.prescale_sel) - 1;
            clk_wr  = wr && paddr == reg_addr(`TTC_CLK_CTRL_ADDR, i);
            ctrl_wr = wr && paddr == reg_addr(`TTC_CNTR_CTRL_ADDR, i);
            creset  = ctrl_wr && w.cntr.cnt_reset;
            eff     = ctrl_wr ? ctrl_word_u'(w & `TTC_CNTR_CTRL_MASK) : m_cntr[i];
            fs      = '0;
            if (creset)                          // Start value, no flags
               m_cnt[i] = eff.cntr.decrement ? (eff.cntr.interval_mode ? m_ivl[i] : '1) : '0;
            else if (tick && !eff.cntr.cnt_dis) begin
               if (eff.cntr.decrement) begin
                  wrap = m_cnt[i] == '0;
                  nxt  = wrap ? (eff.cntr.interval_mode ? m_ivl[i] : '1) : m_cnt[i] - 1'b1;
               end else begin
                  wrap = eff.cntr.interval_mode ? m_cnt[i] >= m_ivl[i] : m_cnt[i] == '1;
                  nxt  = wrap ? '0 : m_cnt[i] + 1'b1;
               end
               fs[`TTC_FLAG_INTERVAL] = wrap & eff.cntr.interval_mode;
               fs[`TTC_FLAG_OVERFLOW] = wrap & ~eff.cntr.interval_mode;
               fs[`TTC_FLAG_MATCH_1]  = eff.cntr.match_en && nxt == m_m1[i];
               fs[`TTC_FLAG_MATCH_2]  = eff.cntr.match_en && nxt == m_m2[i];
               fs[`TTC_FLAG_MATCH_3]  = eff.cntr.match_en && nxt == m_m3[i];
               m_cnt[i] = nxt;
            end
            if (rd && paddr == reg_addr(`TTC_INTR_STAT_ADDR, i))
               m_stat[i] = '0;                   // Clear on read
            m_stat[i] = (m_stat[i] | fs) & `TTC_FLAG_MASK;   // New flag wins
            if (clk_wr)  m_clk[i]  = ctrl_word_u'(w & `TTC_CLK_CTRL_MASK);
            if (ctrl_wr) m_cntr[i] = eff;
            if (wr && paddr == reg_addr(`TTC_INTERVAL_ADDR, i)) m_ivl[i] = pwdata[15:0];
            if (wr && paddr == reg_addr(`TTC_MATCH_1_ADDR, i))  m_m1[i]  = pwdata[15:0];
            if (wr && paddr == reg_addr(`TTC_MATCH_2_ADDR, i))  m_m2[i]  = pwdata[15:0];
            if (wr && paddr == reg_addr(`TTC_MATCH_3_ADDR, i))  m_m3[i]  = pwdata[15:0];
            if (wr && paddr == reg_addr(`TTC_INTR_EN_ADDR, i))
               m_en[i] = flags_t'(pwdata[5:0]) & `TTC_FLAG_MASK;
            m_div[i] = (clk_wr || creset || tick) ? 0 : m_div[i] + 1;   // Divider restart
         end
      end
   end

   // ------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------
   task automatic check_rdata(input logic [7:0] addr, input bus_data_t exp, input bus_data_t act);
      if (act !== exp) begin
         rdata_errs++;
         $display("[ERROR] prdata addr 0x%02h expected 0x%08h actual 0x%08h", addr, exp, act);
      end
   endtask

   task automatic check_irq(input logic [2:0] exp, input logic [2:0] act);
      if (act !== exp) begin
         irq_errs++;
         $display("[ERROR] interrupt expected 0x%01h actual 0x%01h at %0t", exp, act, $time);
      end
   endtask

   task automatic check_flags(input logic [7:0] addr, input flags_t exp, input flags_t act);
      if (act !== exp) begin
         flag_errs++;
         $display("[ERROR] status addr 0x%02h expected 0x%02h actual 0x%02h", addr, exp, act);
      end
   endtask

   always @(negedge pclk) begin
      if (!rst)
         check_irq(model_irq(), interrupt);  // Every cycle
   end

   always @(posedge pclk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("Timeout, run did not finish within %0d cycles", limit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // Bus tasks, called on a falling edge
   // ------------------------------------------------------------
   task automatic bus_write(input logic [`TTC_ADDR_W-1:0] addr, input bus_data_t data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge pclk);
      penable = 1'b1;
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic bus_read(input logic [`TTC_ADDR_W-1:0] addr);
      bus_data_t exp;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      exp     = model_read(addr);            // State seen at end of setup
      @(negedge pclk);
      penable = 1'b1;
      check_rdata(addr, exp, prdata);
      if (addr >= `TTC_INTR_STAT_ADDR && addr < `TTC_INTR_EN_ADDR && addr[1:0] == 2'b00)
         check_flags(addr, flags_t'(exp), flags_t'(prdata));
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_all();
      for (int b = 0; b < 9; b++)
         for (int i = 0; i < 3; i++)
            bus_read(reg_addr(BASES[b], i));
   endtask

   task automatic read_counts();
      for (int i = 0; i < 3; i++) begin
         bus_read(reg_addr(`TTC_CNT_VAL_ADDR, i));
         bus_read(reg_addr(`TTC_INTR_STAT_ADDR, i));
      end
   endtask

   task automatic idle_random();
      repeat (wait_len[wait_idx]) @(negedge pclk);
      wait_idx++;
   endtask

   // ------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------
   initial begin : stim
      logic [3:0] sel;
      logic       d;
      cnt_t       ivl;
      pclk = 1'b0;
      rst  = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      seed = 32'h56e6;
      for (int k = 0; k < N_WAITS; k++) begin
         wait_len[k] = 1 + {$random(seed)} % 60;
         wait_sum += wait_len[k];
      end
      limit = 16 + 2 * N_ACCESS + wait_sum + 200;
      repeat (16) @(negedge pclk);
      rst = 1'b0;
      check_rdata(8'h00, '0, prdata);        // prdata out of reset

      // Reset values and unmapped holes
      read_all();
      bus_read(8'h6C);
      bus_read(8'h70);
      bus_read(8'h02);
      bus_read(8'hFF);

      // Random write and read back, read only targets included
      repeat (3) begin
         for (int b = 0; b < 9; b++)
            for (int i = 0; i < 3; i++)
               bus_write(reg_addr(BASES[b], i), $random(seed));
         read_all();
      end

      // Overflow mode, preload the far end then run
      repeat (4) begin
         for (int i = 0; i < 3; i++) begin
            d   = 1'($random(seed));
            sel = 4'({$random(seed)} % 4);
            bus_write(reg_addr(`TTC_CLK_CTRL_ADDR, i), clk_word(1'($random(seed)), sel));
            bus_write(reg_addr(`TTC_CNTR_CTRL_ADDR, i), cntr_word(1'b1, 1'b0, ~d, 1'b0, 1'b1));
            bus_write(reg_addr(`TTC_CNTR_CTRL_ADDR, i), cntr_word(1'b0, 1'b0, d, 1'b0, 1'b0));
         end
         repeat (2) begin
            idle_random();
            read_counts();
         end
      end

      // Interval mode
      repeat (4) begin
         for (int i = 0; i < 3; i++) begin
            bus_write(reg_addr(`TTC_INTERVAL_ADDR, i), bus_data_t'({$random(seed)} % 36 + 5));
            sel = 4'({$random(seed)} % 3);
            bus_write(reg_addr(`TTC_CLK_CTRL_ADDR, i), clk_word(1'($random(seed)), sel));
            d = 1'($random(seed));
            bus_write(reg_addr(`TTC_CNTR_CTRL_ADDR, i), cntr_word(1'b0, 1'b1, d, 1'b0, 1'b1));
         end
         repeat (2) begin
            idle_random();
            read_counts();
         end
      end

      // Match flags under random enable masks
      repeat (3) begin
         for (int i = 0; i < 3; i++) begin
            ivl = cnt_t'({$random(seed)} % 51 + 10);
            bus_write(reg_addr(`TTC_INTR_EN_ADDR, i), bus_data_t'({$random(seed)} % 64));
            bus_write(reg_addr(`TTC_INTERVAL_ADDR, i), bus_data_t'(ivl));
            bus_write(reg_addr(`TTC_MATCH_1_ADDR, i), bus_data_t'({$random(seed)} % (ivl + 1)));
            bus_write(reg_addr(`TTC_MATCH_2_ADDR, i), bus_data_t'({$random(seed)} % (ivl + 1)));
            bus_write(reg_addr(`TTC_MATCH_3_ADDR, i), bus_data_t'({$random(seed)} % (ivl + 1)));
            bus_write(reg_addr(`TTC_CLK_CTRL_ADDR, i), clk_word(1'($random(seed)), 4'd0));
            d = 1'($random(seed));
            bus_write(reg_addr(`TTC_CNTR_CTRL_ADDR, i), cntr_word(1'b0, 1'b1, d, 1'b1, 1'b1));
         end
         repeat (2) begin
            idle_random();
            read_counts();
         end
      end

      // Clear on read with flags landing on the clear edge
      for (int i = 0; i < 3; i++) begin
         bus_write(reg_addr(`TTC_INTR_EN_ADDR, i), 32'h3F);
         bus_write(reg_addr(`TTC_INTERVAL_ADDR, i), bus_data_t'({$random(seed)} % 3 + 1));
         bus_write(reg_addr(`TTC_CLK_CTRL_ADDR, i), '0);
         d = 1'($random(seed));
         bus_write(reg_addr(`TTC_CNTR_CTRL_ADDR, i), cntr_word(1'b0, 1'b1, d, 1'b1, 1'b1));
      end
      repeat (10)
         for (int i = 0; i < 3; i++)
            bus_read(reg_addr(`TTC_INTR_STAT_ADDR, i));
      for (int i = 0; i < 3; i++)
         bus_write(reg_addr(`TTC_CNTR_CTRL_ADDR, i), cntr_word(1'b1, 1'b1, 1'b0, 1'b0, 1'b0));
      repeat (2)                             // Stopped, second pass reads zero
         for (int i = 0; i < 3; i++)
            bus_read(reg_addr(`TTC_INTR_STAT_ADDR, i));

      $display("Errors: prdata %0d, interrupt %0d, status %0d", rdata_errs, irq_errs, flag_errs);
      if (rdata_errs + irq_errs + flag_errs == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== ttc_lite.sv ====
`timescale 1ns/10ps
`include "ttc_config.svh"

module ttc_lite (
   input  logic                       pclk,
   input  logic                       rst,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [`TTC_ADDR_W-1:0]     paddr,
   input  ttc_pkg::bus_data_t         pwdata,
   output ttc_pkg::bus_data_t         prdata,
   output logic [`TTC_NUM_TIMERS-1:0] interrupt   // Bit n-1 is channel n
);
   import ttc_pkg::*;

   // Per channel register contents, index 0 is channel 1
   ctrl_word_u [`TTC_NUM_TIMERS-1:0] clk_ctrl, cntr_ctrl;
   cnt_t       [`TTC_NUM_TIMERS-1:0] cnt_val, interval, match_1, match_2, match_3;
   flags_t     [`TTC_NUM_TIMERS-1:0] intr, intr_en;
   logic       [`TTC_NUM_TIMERS-1:0] clk_ctrl_sel, cntr_ctrl_sel, interval_sel;
   logic       [`TTC_NUM_TIMERS-1:0] match_1_sel, match_2_sel, match_3_sel;
   logic       [`TTC_NUM_TIMERS-1:0] intr_en_sel, clear_interrupt;

   ttc_interface_lite u_interface (
      .pclk               (pclk),
      .rst                (rst),
      .psel               (psel),
      .penable            (penable),
      .pwrite             (pwrite),
      .paddr              (paddr),
      .clk_ctrl_reg_1     (clk_ctrl[0]),
      .clk_ctrl_reg_2     (clk_ctrl[1]),
      .clk_ctrl_reg_3     (clk_ctrl[2]),
      .cntr_ctrl_reg_1    (cntr_ctrl[0]),
      .cntr_ctrl_reg_2    (cntr_ctrl[1]),
      .cntr_ctrl_reg_3    (cntr_ctrl[2]),
      .counter_val_reg_1  (cnt_val[0]),
      .counter_val_reg_2  (cnt_val[1]),
      .counter_val_reg_3  (cnt_val[2]),
      .interval_reg_1     (interval[0]),
      .interval_reg_2     (interval[1]),
      .interval_reg_3     (interval[2]),
      .match_1_reg_1      (match_1[0]),
      .match_1_reg_2      (match_1[1]),
      .match_1_reg_3      (match_1[2]),
      .match_2_reg_1      (match_2[0]),
      .match_2_reg_2      (match_2[1]),
      .match_2_reg_3      (match_2[2]),
      .match_3_reg_1      (match_3[0]),
      .match_3_reg_2      (match_3[1]),
      .match_3_reg_3      (match_3[2]),
      .interrupt_reg_1    (intr[0]),
      .interrupt_reg_2    (intr[1]),
      .interrupt_reg_3    (intr[2]),
      .interrupt_en_reg_1 (intr_en[0]),
      .interrupt_en_reg_2 (intr_en[1]),
      .interrupt_en_reg_3 (intr_en[2]),
      .prdata             (prdata),
      .clk_ctrl_sel       (clk_ctrl_sel),
      .cntr_ctrl_sel      (cntr_ctrl_sel),
      .interval_sel       (interval_sel),
      .match_1_sel        (match_1_sel),
      .match_2_sel        (match_2_sel),
      .match_3_sel        (match_3_sel),
      .intr_en_sel        (intr_en_sel),
      .clear_interrupt    (clear_interrupt)
   );

   // Three identical channels
   for (genvar n = 0; n < `TTC_NUM_TIMERS; n++) begin : g_ch
      ttc_timer_counter_lite u_channel (
         .pclk             (pclk),
         .rst              (rst),
         .wdata            (pwdata[`TTC_CNT_W-1:0]),
         .clk_ctrl_sel     (clk_ctrl_sel[n]),
         .cntr_ctrl_sel    (cntr_ctrl_sel[n]),
         .interval_sel     (interval_sel[n]),
         .match_1_sel      (match_1_sel[n]),
         .match_2_sel      (match_2_sel[n]),
         .match_3_sel      (match_3_sel[n]),
         .intr_en_sel      (intr_en_sel[n]),
         .clear_interrupt  (clear_interrupt[n]),
         .clk_ctrl_reg     (clk_ctrl[n]),
         .cntr_ctrl_reg    (cntr_ctrl[n]),
         .counter_val_reg  (cnt_val[n]),
         .interval_reg     (interval[n]),
         .match_1_reg      (match_1[n]),
         .match_2_reg      (match_2[n]),
         .match_3_reg      (match_3[n]),
         .interrupt_reg    (intr[n]),
         .interrupt_en_reg (intr_en[n]),
         .interrupt        (interrupt[n])
      );
   end

endmodule

// ==== ttc_timer_counter_lite.sv ====
`timescale 1ns/10ps
`include "ttc_config.svh"

module ttc_timer_counter_lite (
   input  logic                pclk,
   input  logic                rst,
   input  ttc_pkg::cnt_t       wdata,            // Low half of pwdata
   input  logic                clk_ctrl_sel,
   input  logic                cntr_ctrl_sel,
   input  logic                interval_sel,
   input  logic                match_1_sel,
   input  logic                match_2_sel,
   input  logic                match_3_sel,
   input  logic                intr_en_sel,
   input  logic                clear_interrupt,  // Status read in progress
   output ttc_pkg::ctrl_word_u clk_ctrl_reg,
   output ttc_pkg::ctrl_word_u cntr_ctrl_reg,
   output ttc_pkg::cnt_t       counter_val_reg,
   output ttc_pkg::cnt_t       interval_reg,
   output ttc_pkg::cnt_t       match_1_reg,
   output ttc_pkg::cnt_t       match_2_reg,
   output ttc_pkg::cnt_t       match_3_reg,
   output ttc_pkg::flags_t     interrupt_reg,
   output ttc_pkg::flags_t     interrupt_en_reg,
   output logic                interrupt
);
   import ttc_pkg::*;

   ctrl_word_u wr_word;      // Write word through the union
   ctrl_word_u cntr_eff;     // Counter control seen by the engine
   logic       cnt_reset;
   logic       tick;
   flags_t     flag_set;

   assign wr_word   = wdata[`TTC_CTRL_W-1:0];
   assign cnt_reset = cntr_ctrl_sel & wr_word.cntr.cnt_reset;

   // A control write steers the engine on its own edge, so a cnt_reset
   // loads with the mode bits written alongside it
   assign cntr_eff = cntr_ctrl_sel ? (wr_word & `TTC_CNTR_CTRL_MASK) : cntr_ctrl_reg;

   // ------------------------------------------------------------
   // Register bank
   // ------------------------------------------------------------
   always_ff @(posedge pclk) begin
      if (rst) begin
         clk_ctrl_reg     <= '0;
         cntr_ctrl_reg    <= `TTC_CNTR_CTRL_RST;
         interval_reg     <= '0;
         match_1_reg      <= '0;
         match_2_reg      <= '0;
         match_3_reg      <= '0;
         interrupt_en_reg <= '0;
      end else begin
         if (clk_ctrl_sel)
            clk_ctrl_reg <= wr_word & `TTC_CLK_CTRL_MASK;
         if (cntr_ctrl_sel)
            cntr_ctrl_reg <= cntr_eff;                // cnt_reset not stored
         if (interval_sel)
            interval_reg <= wdata;
         if (match_1_sel)
            match_1_reg <= wdata;
         if (match_2_sel)
            match_2_reg <= wdata;
         if (match_3_sel)
            match_3_reg <= wdata;
         if (intr_en_sel)
            interrupt_en_reg <= wdata[`TTC_FLAG_W-1:0] & `TTC_FLAG_MASK;
      end
   end

   // Sticky status, a new flag beats the clear
   always_ff @(posedge pclk) begin
      if (rst)
         interrupt_reg <= '0;
      else
         interrupt_reg <= ((clear_interrupt ? '0 : interrupt_reg) | flag_set)
                          & `TTC_FLAG_MASK;
   end

   assign interrupt = |(interrupt_reg & interrupt_en_reg);

   // ------------------------------------------------------------
   // Tick source and counter
   // ------------------------------------------------------------
   ttc_prescaler u_prescaler (
      .pclk     (pclk),
      .rst      (rst),
      .restart  (clk_ctrl_sel | cnt_reset),
      .clk_ctrl (clk_ctrl_reg),
      .tick     (tick)
   );

   ttc_count_engine u_count_engine (
      .pclk      (pclk),
      .rst       (rst),
      .tick      (tick),
      .cntr_ctrl (cntr_eff),
      .cnt_reset (cnt_reset),
      .interval  (interval_reg),
      .match_1   (match_1_reg),
      .match_2   (match_2_reg),
      .match_3   (match_3_reg),
      .count     (counter_val_reg),
      .flag_set  (flag_set)
   );

endmodule

// ==== ttc_count_engine.sv ====
`timescale 1ns/10ps
`include "ttc_config.svh"

module ttc_count_engine (
   input  logic                pclk,
   input  logic                rst,
   input  logic                tick,
   input  ttc_pkg::ctrl_word_u cntr_ctrl,   // Control as of this edge
   input  logic                cnt_reset,
   input  ttc_pkg::cnt_t       interval,
   input  ttc_pkg::cnt_t       match_1,
   input  ttc_pkg::cnt_t       match_2,
   input  ttc_pkg::cnt_t       match_3,
   output ttc_pkg::cnt_t       count,
   output ttc_pkg::flags_t     flag_set     // One pulse per flag, same edge as count
);
   import ttc_pkg::*;

   localparam cnt_t CNT_MAX = '1;

   logic dec;
   logic ivl_mode;
   logic match_en;
   logic step;          // Counter moves on this edge
   logic wrap;          // End of range reached
   cnt_t count_next;
   cnt_t reset_val;

   assign dec      = cntr_ctrl.cntr.decrement;
   assign ivl_mode = cntr_ctrl.cntr.interval_mode;
   assign match_en = cntr_ctrl.cntr.match_en;
   assign step     = tick & ~cntr_ctrl.cntr.cnt_dis & ~cnt_reset;

   // ------------------------------------------------------------
   // Next count and wrap detect
   // ------------------------------------------------------------
   always_comb begin
      if (dec) begin
         wrap       = (count == '0);
         count_next = count - 1'b1;
         if (wrap)
            count_next = ivl_mode ? interval : CNT_MAX;   // Reload
      end else begin
         wrap       = ivl_mode ? (count >= interval) : (count == CNT_MAX);
         count_next = wrap ? '0 : count + 1'b1;
      end
   end

   // Start value for cnt_reset
   always_comb begin
      if (dec && ivl_mode)
         reset_val = interval;
      else if (dec)
         reset_val = CNT_MAX;
      else
         reset_val = '0;
   end

   always_comb begin
      flag_set = '0;                               // Quiet on cnt_reset and idle cycles
      if (step) begin
         flag_set[`TTC_FLAG_INTERVAL] = wrap & ivl_mode;
         flag_set[`TTC_FLAG_OVERFLOW] = wrap & ~ivl_mode;
         flag_set[`TTC_FLAG_MATCH_1]  = match_en & (count_next == match_1);
         flag_set[`TTC_FLAG_MATCH_2]  = match_en & (count_next == match_2);
         flag_set[`TTC_FLAG_MATCH_3]  = match_en & (count_next == match_3);
      end
   end

   always_ff @(posedge pclk) begin
      if (rst)
         count <= '0;
      else if (cnt_reset)
         count <= reset_val;
      else if (step)
         count <= count_next;
   end

endmodule

// ==== ttc_prescaler.sv ====
`timescale 1ns/10ps
`include "ttc_config.svh"

module ttc_prescaler (
   input  logic                pclk,
   input  logic                rst,
   input  logic                restart,    // Clock control write or cnt_reset
   input  ttc_pkg::ctrl_word_u clk_ctrl,
   output logic                tick
);

   logic [`TTC_PRESCALE_W-1:0] div;        // Cycles since last tick
   logic [`TTC_PRESCALE_W-1:0] div_last;   // 2^(sel+1) - 1

   // Shift past the top gives all ones for sel = 15
   assign div_last = ~({`TTC_PRESCALE_W{1'b1}} << (clk_ctrl.clk.prescale_sel + 1));

   // Undivided when the prescaler is off
   assign tick = clk_ctrl.clk.prescale_en ? (div == div_last) : 1'b1;

   always_ff @(posedge pclk) begin
      if (rst || restart || tick)
         div <= '0;
      else
         div <= div + 1'b1;
   end

endmodule

// ==== ttc_interface_lite.sv ====
`timescale 1ns/10ps
`include "ttc_config.svh"

module ttc_interface_lite (
   input  logic                       pclk,
   input  logic                       rst,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [`TTC_ADDR_W-1:0]     paddr,
   input  ttc_pkg::ctrl_word_u        clk_ctrl_reg_1,
   input  ttc_pkg::ctrl_word_u        clk_ctrl_reg_2,
   input  ttc_pkg::ctrl_word_u        clk_ctrl_reg_3,
   input  ttc_pkg::ctrl_word_u        cntr_ctrl_reg_1,
   input  ttc_pkg::ctrl_word_u        cntr_ctrl_reg_2,
   input  ttc_pkg::ctrl_word_u        cntr_ctrl_reg_3,
   input  ttc_pkg::cnt_t              counter_val_reg_1,
   input  ttc_pkg::cnt_t              counter_val_reg_2,
   input  ttc_pkg::cnt_t              counter_val_reg_3,
   input  ttc_pkg::cnt_t              interval_reg_1,
   input  ttc_pkg::cnt_t              interval_reg_2,
   input  ttc_pkg::cnt_t              interval_reg_3,
   input  ttc_pkg::cnt_t              match_1_reg_1,
   input  ttc_pkg::cnt_t              match_1_reg_2,
   input  ttc_pkg::cnt_t              match_1_reg_3,
   input  ttc_pkg::cnt_t              match_2_reg_1,
   input  ttc_pkg::cnt_t              match_2_reg_2,
   input  ttc_pkg::cnt_t              match_2_reg_3,
   input  ttc_pkg::cnt_t              match_3_reg_1,
   input  ttc_pkg::cnt_t              match_3_reg_2,
   input  ttc_pkg::cnt_t              match_3_reg_3,
   input  ttc_pkg::flags_t            interrupt_reg_1,
   input  ttc_pkg::flags_t            interrupt_reg_2,
   input  ttc_pkg::flags_t            interrupt_reg_3,
   input  ttc_pkg::flags_t            interrupt_en_reg_1,
   input  ttc_pkg::flags_t            interrupt_en_reg_2,
   input  ttc_pkg::flags_t            interrupt_en_reg_3,
   output ttc_pkg::bus_data_t         prdata,
   output logic [`TTC_NUM_TIMERS-1:0] clk_ctrl_sel,
   output logic [`TTC_NUM_TIMERS-1:0] cntr_ctrl_sel,
   output logic [`TTC_NUM_TIMERS-1:0] interval_sel,
   output logic [`TTC_NUM_TIMERS-1:0] match_1_sel,
   output logic [`TTC_NUM_TIMERS-1:0] match_2_sel,
   output logic [`TTC_NUM_TIMERS-1:0] match_3_sel,
   output logic [`TTC_NUM_TIMERS-1:0] intr_en_sel,
   output logic [`TTC_NUM_TIMERS-1:0] clear_interrupt
);
   import ttc_pkg::*;

   ctrl_word_u [`TTC_NUM_TIMERS-1:0] clk_ctrl, cntr_ctrl;
   cnt_t       [`TTC_NUM_TIMERS-1:0] cnt_val, interval, match_1, match_2, match_3;
   flags_t     [`TTC_NUM_TIMERS-1:0] intr, intr_en;
   logic       rd_setup;        // Setup phase of a read
   logic       rd_access;
   logic       wr_access;
   bus_data_t  rd_val;          // Muxed read value

   // Channel n decode, register base + 4n
   function automatic logic hit(input logic [`TTC_ADDR_W-1:0] addr,
                                input logic [`TTC_ADDR_W-1:0] base, input int n);
      return addr == base + `TTC_ADDR_W'(4 * n);
   endfunction

   // Gather the loose channel ports, index 0 is channel 1
   assign clk_ctrl  = {clk_ctrl_reg_3, clk_ctrl_reg_2, clk_ctrl_reg_1};
   assign cntr_ctrl = {cntr_ctrl_reg_3, cntr_ctrl_reg_2, cntr_ctrl_reg_1};
   assign cnt_val   = {counter_val_reg_3, counter_val_reg_2, counter_val_reg_1};
   assign interval  = {interval_reg_3, interval_reg_2, interval_reg_1};
   assign match_1   = {match_1_reg_3, match_1_reg_2, match_1_reg_1};
   assign match_2   = {match_2_reg_3, match_2_reg_2, match_2_reg_1};
   assign match_3   = {match_3_reg_3, match_3_reg_2, match_3_reg_1};
   assign intr      = {interrupt_reg_3, interrupt_reg_2, interrupt_reg_1};
   assign intr_en   = {interrupt_en_reg_3, interrupt_en_reg_2, interrupt_en_reg_1};

   assign rd_setup  = psel & ~penable & ~pwrite;
   assign rd_access = psel & penable & ~pwrite;
   assign wr_access = psel & penable & pwrite;   // Write lands at end of access

   // ------------------------------------------------------------
   // Address decode, select pulses and read mux
   // ------------------------------------------------------------
   always_comb begin
      rd_val = '0;                               // Unmapped reads zero
      for (int n = 0; n < `TTC_NUM_TIMERS; n++) begin
         clk_ctrl_sel[n]    = wr_access & hit(paddr, `TTC_CLK_CTRL_ADDR, n);
         cntr_ctrl_sel[n]   = wr_access & hit(paddr, `TTC_CNTR_CTRL_ADDR, n);
         interval_sel[n]    = wr_access & hit(paddr, `TTC_INTERVAL_ADDR, n);
         match_1_sel[n]     = wr_access & hit(paddr, `TTC_MATCH_1_ADDR, n);
         match_2_sel[n]     = wr_access & hit(paddr, `TTC_MATCH_2_ADDR, n);
         match_3_sel[n]     = wr_access & hit(paddr, `TTC_MATCH_3_ADDR, n);
         intr_en_sel[n]     = wr_access & hit(paddr, `TTC_INTR_EN_ADDR, n);
         clear_interrupt[n] = rd_access & hit(paddr, `TTC_INTR_STAT_ADDR, n);

         if (hit(paddr, `TTC_CLK_CTRL_ADDR, n))
            rd_val = bus_data_t'(clk_ctrl[n]);
         else if (hit(paddr, `TTC_CNTR_CTRL_ADDR, n))
            rd_val = bus_data_t'(cntr_ctrl[n]);
         else if (hit(paddr, `TTC_CNT_VAL_ADDR, n))
            rd_val = bus_data_t'(cnt_val[n]);
         else if (hit(paddr, `TTC_INTERVAL_ADDR, n))
            rd_val = bus_data_t'(interval[n]);
         else if (hit(paddr, `TTC_MATCH_1_ADDR, n))
            rd_val = bus_data_t'(match_1[n]);
         else if (hit(paddr, `TTC_MATCH_2_ADDR, n))
            rd_val = bus_data_t'(match_2[n]);
         else if (hit(paddr, `TTC_MATCH_3_ADDR, n))
            rd_val = bus_data_t'(match_3[n]);
         else if (hit(paddr, `TTC_INTR_STAT_ADDR, n))
            rd_val = bus_data_t'(intr[n]);
         else if (hit(paddr, `TTC_INTR_EN_ADDR, n))
            rd_val = bus_data_t'(intr_en[n]);
      end
   end

   // Captured at end of setup, held through access
   always_ff @(posedge pclk) begin
      if (rst)
         prdata <= '0;
      else if (rd_setup)
         prdata <= rd_val;
   end

endmodule

// ==== ttc_pkg.sv ====
`include "ttc_config.svh"

package ttc_pkg;

   typedef logic [`TTC_CNT_W-1:0]  cnt_t;       // Count, interval, match
   typedef logic [`TTC_DATA_W-1:0] bus_data_t;  // APB word
   typedef logic [`TTC_FLAG_W-1:0] flags_t;     // Status and enable

   // Clock control view, LSB first: prescale_en, prescale_sel
   typedef struct packed {
      logic [1:0] reserved;
      logic [3:0] prescale_sel;   // Divide by 2^(sel+1)
      logic       prescale_en;
   } clk_ctrl_t;

   // Counter control view
   typedef struct packed {
      logic [1:0] reserved;
      logic       cnt_reset;      // Write only, reads zero
      logic       match_en;
      logic       decrement;
      logic       interval_mode;
      logic       cnt_dis;        // Counter disable
   } cntr_ctrl_t;

   // Low write-data bits, decoded by whichever select is active
   typedef union packed {
      clk_ctrl_t  clk;
      cntr_ctrl_t cntr;
   } ctrl_word_u;

endpackage

// ==== ttc_config.svh ====
`ifndef TTC_CONFIG_SVH
`define TTC_CONFIG_SVH

// ------------------------------------------------------------
// Sizes
// ------------------------------------------------------------
`define TTC_NUM_TIMERS      3
`define TTC_CNT_W           16     // Counter, interval, match width
`define TTC_DATA_W          32     // APB data width
`define TTC_ADDR_W          8
`define TTC_FLAG_W          6      // Status / enable word
`define TTC_CTRL_W          7      // Clock and counter control word
`define TTC_PRESCALE_W      16     // Divider for up to 2^16 cycles

// ------------------------------------------------------------
// Address map, channel n at base + 4*(n-1)
// ------------------------------------------------------------
`define TTC_CLK_CTRL_ADDR   8'h00
`define TTC_CNTR_CTRL_ADDR  8'h0C
`define TTC_CNT_VAL_ADDR    8'h18  // Read only
`define TTC_INTERVAL_ADDR   8'h24
`define TTC_MATCH_1_ADDR    8'h30
`define TTC_MATCH_2_ADDR    8'h3C
`define TTC_MATCH_3_ADDR    8'h48
`define TTC_INTR_STAT_ADDR  8'h54  // Read only, clear on read
`define TTC_INTR_EN_ADDR    8'h60

// ------------------------------------------------------------
// Control words and flags
// ------------------------------------------------------------
`define TTC_CLK_CTRL_MASK   7'h1F  // prescale_en, prescale_sel
`define TTC_CNTR_CTRL_MASK  7'h0F  // Drops cnt_reset and reserved bits
`define TTC_CNTR_CTRL_RST   7'h01  // Counter disabled out of reset
`define TTC_FLAG_INTERVAL   0
`define TTC_FLAG_MATCH_1    1
`define TTC_FLAG_MATCH_2    2
`define TTC_FLAG_MATCH_3    3
`define TTC_FLAG_OVERFLOW   4
`define TTC_FLAG_MASK       6'h1F  // Bit 5 reserved

`endif
